//--- design/cp0_pkg.sv
package cp0_pkg;

    // cp0 data path is one machine word
    localparam int DATA_W = 32;

    // implemented register numbers
    localparam logic [4:0] CP0_INDEX    = 5'd0;
    localparam logic [4:0] CP0_ENTRYLO0 = 5'd2;
    localparam logic [4:0] CP0_ENTRYLO1 = 5'd3;
    localparam logic [4:0] CP0_BADVADDR = 5'd8;
    localparam logic [4:0] CP0_COUNT    = 5'd9;
    localparam logic [4:0] CP0_ENTRYHI  = 5'd10;
    localparam logic [4:0] CP0_COMPARE  = 5'd11;
    localparam logic [4:0] CP0_STATUS   = 5'd12;
    localparam logic [4:0] CP0_CAUSE    = 5'd13;
    localparam logic [4:0] CP0_EPC      = 5'd14;

    // status bits, im is 8 bits wide from here
    localparam int STATUS_IE  = 0;
    localparam int STATUS_EXL = 1;
    localparam int STATUS_IM  = 8;
    localparam int STATUS_BEV = 22;

    // cause fields, lowest bit of each
    localparam int CAUSE_EXCCODE = 2;
    localparam int CAUSE_IP_SW   = 8;
    localparam int CAUSE_IP_HW   = 10;
    localparam int CAUSE_TI      = 30;
    localparam int CAUSE_BD      = 31;

    // index probe-failure flag and entryhi vpn2 start
    localparam int INDEX_P      = 31;
    localparam int ENTRYHI_VPN2 = 13;

    // only bev survives reset
    localparam logic [DATA_W-1:0] STATUS_RESET = 32'h0040_0000;

    // pfn, c, d, v, g
    localparam logic [DATA_W-1:0] ENTRYLO_MASK = 32'h03ff_ffff;
    // vpn2 and asid
    localparam logic [DATA_W-1:0] ENTRYHI_MASK = 32'hffff_e0ff;
    // im, exl, ie writable; bev is read only
    localparam logic [DATA_W-1:0] STATUS_WMASK = 32'h0000_ff03;
    localparam logic [DATA_W-1:0] STATUS_RMASK = 32'h0040_ff03;
    // bd, ti, ip_sw, exccode; ip_hw comes from the pins
    localparam logic [DATA_W-1:0] CAUSE_RMASK  = 32'hc000_037c;

    typedef struct packed {
        logic              we;
        logic [4:0]        addr;
        logic [DATA_W-1:0] data;
    } cp0_wr_t;

    typedef struct packed {
        logic              valid;
        logic              bd;
        logic [4:0]        code;
        logic [DATA_W-1:0] epc;
        logic [DATA_W-1:0] badvaddr;
        logic              badvaddr_we;
    } exc_req_t;

    typedef struct packed {
        logic tlbwi;
        logic tlbr;
        logic tlbp;
    } tlb_op_t;

endpackage

//--- design/tlb_pkg.sv
package tlb_pkg;

    // joint tlb entry field widths
    localparam int VPN2_W     = 19;
    localparam int ASID_W     = 8;
    localparam int PFN_W      = 20;
    localparam int CACHE_W    = 3;

    // 4 KB pages only, no pagemask
    localparam int PAGE_OFS_W = 12;

    // vpn2, even/odd select bit, page offset
    localparam int VA_W       = VPN2_W + 1 + PAGE_OFS_W;
    localparam int PA_W       = PFN_W + PAGE_OFS_W;

    // wide enough for a 32 entry tlb
    localparam int MAX_IDX_W  = 5;

    // same bit order as entrylo 25:1
    typedef struct packed {
        logic [PFN_W-1:0]   pfn;
        logic [CACHE_W-1:0] c;
        logic               d;
        logic               v;
    } tlb_page_t;

    // 19 + 8 + 1 + 25 + 25 = 78 bits
    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        logic              g;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_t;

    typedef struct packed {
        logic                 hit;
        logic [MAX_IDX_W-1:0] index;
        logic [PA_W-1:0]      pa;
        logic                 valid;
        logic                 dirty;
        logic                 cached;
    } tlb_result_t;

endpackage

//--- design/tlb_lookup.sv
module tlb_lookup #(
    parameter int TLB_ENTRIES = 8,
    localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
    input  tlb_pkg::tlb_entry_t [TLB_ENTRIES-1:0] entries_i,
    input  logic [tlb_pkg::VA_W-1:0]              va_i,
    input  logic [tlb_pkg::ASID_W-1:0]            asid_i,
    output tlb_pkg::tlb_result_t                  result_o
);
    import tlb_pkg::*;

    logic [TLB_ENTRIES-1:0] match;
    logic [IDX_W-1:0]       hit_idx;
    tlb_entry_t             hit_entry;
    tlb_page_t              page;

    // vpn2 compare, asid ignored for global entries
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = (entries_i[i].vpn2 == va_i[VA_W-1 -: VPN2_W])
                    && (entries_i[i].g || entries_i[i].asid == asid_i);
        end
    end

    // scan down so the lowest match is left standing
    always_comb begin
        hit_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_idx = IDX_W'(i);
            end
        end
    end

    assign hit_entry = entries_i[hit_idx];

    // bit 12 picks the odd page
    assign page = va_i[PAGE_OFS_W] ? hit_entry.page1 : hit_entry.page0;

    // all fields zero on a miss
    always_comb begin
        result_o = '0;
        if (|match) begin
            result_o.hit    = 1'b1;
            result_o.index  = MAX_IDX_W'(hit_idx);
            result_o.pa     = {page.pfn, va_i[PAGE_OFS_W-1:0]};
            result_o.valid  = page.v;
            result_o.dirty  = page.d;
            // c == 3 is cacheable noncoherent
            result_o.cached = (page.c == CACHE_W'(3));
        end
    end

endmodule

//--- design/tlb_array.sv
module tlb_array #(
    parameter int TLB_ENTRIES = 8,
    localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  tlbwi_i,
    input  logic [IDX_W-1:0]                      index_i,
    input  tlb_pkg::tlb_entry_t                   wr_entry_i,
    output tlb_pkg::tlb_entry_t                   rd_entry_o,
    output tlb_pkg::tlb_entry_t [TLB_ENTRIES-1:0] entries_o
);
    import tlb_pkg::*;

    // one copy, shared by the probe and data lookups
    tlb_entry_t [TLB_ENTRIES-1:0] entry_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_q <= '0;
        end else if (tlbwi_i) begin
            entry_q[index_i] <= wr_entry_i;
        end
    end

    // tlbr source, same slot as tlbwi
    assign rd_entry_o = entry_q[index_i];

    // new entry visible to lookups the cycle after tlbwi
    assign entries_o  = entry_q;

endmodule

//--- design/cp0_regs.sv
module cp0_regs #(
    parameter int TLB_ENTRIES = 8,
    localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
    input  logic                          clk,
    input  logic                          rst,
    input  cp0_pkg::cp0_wr_t              wr_i,
    input  logic [4:0]                    rd_addr_i,
    input  cp0_pkg::exc_req_t             exc_i,
    input  logic                          clear_exl_i,
    input  logic [5:0]                    hw_int_i,
    input  cp0_pkg::tlb_op_t              tlb_op_i,
    input  tlb_pkg::tlb_entry_t           rd_entry_i,
    input  tlb_pkg::tlb_result_t          probe_i,
    output logic [cp0_pkg::DATA_W-1:0]    rd_data_o,
    output logic [cp0_pkg::DATA_W-1:0]    epc_o,
    output logic                          exl_o,
    output logic                          allow_int_o,
    output logic [7:0]                    interrupt_flag_o,
    output tlb_pkg::tlb_entry_t           wr_entry_o,
    output logic [IDX_W-1:0]              index_o,
    output logic [tlb_pkg::ASID_W-1:0]    asid_o,
    output logic [tlb_pkg::VPN2_W-1:0]    probe_vpn2_o
);
    import cp0_pkg::*;

    // index keeps only its slot field, read adds the p flag
    localparam logic [DATA_W-1:0] INDEX_WMASK = DATA_W'(TLB_ENTRIES - 1);
    localparam logic [DATA_W-1:0] INDEX_RMASK = INDEX_WMASK | (DATA_W'(1) << INDEX_P);

    logic [DATA_W-1:0] index_q;
    logic [DATA_W-1:0] entrylo0_q;
    logic [DATA_W-1:0] entrylo1_q;
    logic [DATA_W-1:0] badvaddr_q;
    logic [DATA_W-1:0] count_q;
    logic [DATA_W-1:0] entryhi_q;
    logic [DATA_W-1:0] compare_q;
    logic [DATA_W-1:0] status_q;
    logic [DATA_W-1:0] cause_q;
    logic [DATA_W-1:0] epc_q;
    // count advances on every second edge
    logic              count_tick_q;
    logic [DATA_W-1:0] count_next;
    logic [7:0]        ip;

    function automatic logic [DATA_W-1:0] wmerge(
        input logic [DATA_W-1:0] old_v,
        input logic [DATA_W-1:0] new_v,
        input logic [DATA_W-1:0] mask
    );
        return (old_v & ~mask) | (new_v & mask);
    endfunction

    assign count_next = count_q + DATA_W'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            index_q      <= '0;
            entrylo0_q   <= '0;
            entrylo1_q   <= '0;
            badvaddr_q   <= '0;
            count_q      <= '0;
            entryhi_q    <= '0;
            compare_q    <= '0;
            status_q     <= STATUS_RESET;
            cause_q      <= '0;
            epc_q        <= '0;
            count_tick_q <= 1'b0;
        end else begin
            count_tick_q <= ~count_tick_q;
            // timer fires when count steps onto compare
            if (count_tick_q) begin
                count_q <= count_next;
                if (count_next == compare_q) begin
                    cause_q[CAUSE_TI] <= 1'b1;
                end
            end

            // mtc0
            if (wr_i.we) begin
                case (wr_i.addr)
                    CP0_INDEX:    index_q    <= wmerge(index_q, wr_i.data, INDEX_WMASK);
                    CP0_ENTRYLO0: entrylo0_q <= wr_i.data & ENTRYLO_MASK;
                    CP0_ENTRYLO1: entrylo1_q <= wr_i.data & ENTRYLO_MASK;
                    CP0_COUNT:    count_q    <= wr_i.data;
                    CP0_ENTRYHI:  entryhi_q  <= wr_i.data & ENTRYHI_MASK;
                    CP0_COMPARE: begin
                        compare_q         <= wr_i.data;
                        // new compare acknowledges the timer
                        cause_q[CAUSE_TI] <= 1'b0;
                    end
                    CP0_STATUS:   status_q   <= wmerge(status_q, wr_i.data, STATUS_WMASK);
                    // software interrupt bits only
                    CP0_CAUSE:    cause_q[CAUSE_IP_SW +: 2] <= wr_i.data[CAUSE_IP_SW +: 2];
                    CP0_EPC:      epc_q      <= wr_i.data;
                    // badvaddr and unknown numbers ignore writes
                    default: ;
                endcase
            end

            // tlbr, g goes to both entrylo copies
            if (tlb_op_i.tlbr) begin
                entryhi_q  <= {rd_entry_i.vpn2, 5'b0, rd_entry_i.asid};
                entrylo0_q <= {6'b0, rd_entry_i.page0, rd_entry_i.g};
                entrylo1_q <= {6'b0, rd_entry_i.page1, rd_entry_i.g};
            end

            // tlbp, slot field kept on a miss
            if (tlb_op_i.tlbp) begin
                index_q[INDEX_P] <= ~probe_i.hit;
                if (probe_i.hit) begin
                    index_q[IDX_W-1:0] <= probe_i.index[IDX_W-1:0];
                end
            end

            if (clear_exl_i) begin
                status_q[STATUS_EXL] <= 1'b0;
            end

            // exception entry overrides any mtc0 in the same cycle
            if (exc_i.valid) begin
                epc_q                      <= exc_i.epc;
                cause_q[CAUSE_BD]          <= exc_i.bd;
                cause_q[CAUSE_EXCCODE +: 5] <= exc_i.code;
                status_q[STATUS_EXL]       <= 1'b1;
                if (exc_i.badvaddr_we) begin
                    badvaddr_q <= exc_i.badvaddr;
                    entryhi_q[DATA_W-1:ENTRYHI_VPN2] <=
                        exc_i.badvaddr[DATA_W-1:ENTRYHI_VPN2];
                end
            end
        end
    end

    // mfc0, combinational
    always_comb begin
        case (rd_addr_i)
            CP0_INDEX:    rd_data_o = index_q & INDEX_RMASK;
            CP0_ENTRYLO0: rd_data_o = entrylo0_q & ENTRYLO_MASK;
            CP0_ENTRYLO1: rd_data_o = entrylo1_q & ENTRYLO_MASK;
            CP0_BADVADDR: rd_data_o = badvaddr_q;
            CP0_COUNT:    rd_data_o = count_q;
            CP0_ENTRYHI:  rd_data_o = entryhi_q & ENTRYHI_MASK;
            CP0_COMPARE:  rd_data_o = compare_q;
            CP0_STATUS:   rd_data_o = status_q & STATUS_RMASK;
            // hw lines shown live in ip_hw
            CP0_CAUSE:    rd_data_o = (cause_q & CAUSE_RMASK)
                                    | (DATA_W'(hw_int_i) << CAUSE_IP_HW);
            CP0_EPC:      rd_data_o = epc_q;
            default:      rd_data_o = '0;
        endcase
    end

    // ip7 shares its line with the timer
    assign ip = {hw_int_i[5] | cause_q[CAUSE_TI], hw_int_i[4:0], cause_q[CAUSE_IP_SW +: 2]};

    assign interrupt_flag_o = status_q[STATUS_IM +: 8] & ip;
    assign allow_int_o      = status_q[STATUS_IE] & ~status_q[STATUS_EXL] & ~exc_i.valid;
    assign exl_o            = status_q[STATUS_EXL];
    assign epc_o            = epc_q;

    // candidate entry for tlbwi, global only if both halves say so
    assign wr_entry_o.vpn2  = entryhi_q[DATA_W-1:ENTRYHI_VPN2];
    assign wr_entry_o.asid  = entryhi_q[tlb_pkg::ASID_W-1:0];
    assign wr_entry_o.g     = entrylo0_q[0] & entrylo1_q[0];
    assign wr_entry_o.page0 = entrylo0_q[25:1];
    assign wr_entry_o.page1 = entrylo1_q[25:1];

    assign index_o      = index_q[IDX_W-1:0];
    assign asid_o       = entryhi_q[tlb_pkg::ASID_W-1:0];
    assign probe_vpn2_o = entryhi_q[DATA_W-1:ENTRYHI_VPN2];

endmodule

//--- design/cp0_tlb_top.sv
module cp0_tlb_top #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  cp0_pkg::cp0_wr_t           wr_i,
    input  logic [4:0]                 rd_addr_i,
    output logic [cp0_pkg::DATA_W-1:0] rd_data_o,
    input  cp0_pkg::exc_req_t          exc_i,
    input  logic                       clear_exl_i,
    input  logic [5:0]                 hw_int_i,
    input  cp0_pkg::tlb_op_t           tlb_op_i,
    input  logic [cp0_pkg::DATA_W-1:0] daddr_i,
    output logic [cp0_pkg::DATA_W-1:0] epc_o,
    output logic                       exl_o,
    output logic                       allow_int_o,
    output logic [7:0]                 interrupt_flag_o,
    output tlb_pkg::tlb_result_t       dtrans_o
);
    import tlb_pkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    tlb_entry_t [TLB_ENTRIES-1:0] entries;
    tlb_entry_t                   wr_entry;
    tlb_entry_t                   rd_entry;
    tlb_result_t                  probe_res;
    logic [IDX_W-1:0]             index;
    logic [ASID_W-1:0]            asid;
    logic [VPN2_W-1:0]            probe_vpn2;
    logic [VA_W-1:0]              probe_va;

    // probe matches on vpn2 alone, low bits zero
    assign probe_va = {probe_vpn2, {(VA_W - VPN2_W){1'b0}}};

    cp0_regs #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) u_cp0_regs (
        .clk             (clk),
        .rst             (rst),
        .wr_i            (wr_i),
        .rd_addr_i       (rd_addr_i),
        .exc_i           (exc_i),
        .clear_exl_i     (clear_exl_i),
        .hw_int_i        (hw_int_i),
        .tlb_op_i        (tlb_op_i),
        .rd_entry_i      (rd_entry),
        .probe_i         (probe_res),
        .rd_data_o       (rd_data_o),
        .epc_o           (epc_o),
        .exl_o           (exl_o),
        .allow_int_o     (allow_int_o),
        .interrupt_flag_o(interrupt_flag_o),
        .wr_entry_o      (wr_entry),
        .index_o         (index),
        .asid_o          (asid),
        .probe_vpn2_o    (probe_vpn2)
    );

    tlb_array #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) u_tlb_array (
        .clk       (clk),
        .rst       (rst),
        .tlbwi_i   (tlb_op_i.tlbwi),
        .index_i   (index),
        .wr_entry_i(wr_entry),
        .rd_entry_o(rd_entry),
        .entries_o (entries)
    );

    // tlbp source, result latched by cp0_regs
    tlb_lookup #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) u_probe_lookup (
        .entries_i(entries),
        .va_i     (probe_va),
        .asid_i   (asid),
        .result_o (probe_res)
    );

    // data side translation, same cycle as daddr_i
    tlb_lookup #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) u_data_lookup (
        .entries_i(entries),
        .va_i     (daddr_i),
        .asid_i   (asid),
        .result_o (dtrans_o)
    );

endmodule

//--- dv/cp0_tlb_tb.sv
module cp0_tlb_tb;
    import cp0_pkg::*;
    import tlb_pkg::*;

    localparam int TLB_ENTRIES = 8;

    // register masks, straight from the cp0 register map
    localparam logic [31:0] M_INDEX    = 32'(TLB_ENTRIES - 1);
    localparam logic [31:0] M_ENTRYLO  = 32'h03ff_ffff;
    localparam logic [31:0] M_ENTRYHI  = 32'hffff_e0ff;
    localparam logic [31:0] M_STATUS   = 32'h0000_ff03;
    localparam logic [31:0] M_CAUSE_SW = 32'h0000_0300;
    localparam logic [31:0] BEV_BIT    = 32'h0040_0000;
    localparam logic [4:0]  CP0_NONE   = 5'd20;

    logic          clk;
    logic          rst;
    cp0_wr_t       wr;
    logic [4:0]    rd_addr;
    logic [31:0]   rd_data;
    exc_req_t      exc;
    logic          clear_exl;
    logic [5:0]    hw_int;
    tlb_op_t       tlb_op;
    logic [31:0]   daddr;
    logic [31:0]   epc;
    logic          exl;
    logic          allow_int;
    logic [7:0]    interrupt_flag;
    tlb_result_t   dtrans;

    logic [31:0]   rng_state;
    int            checks;
    int            errors;
    int            checks_at;
    int            errors_at;
    // model of what went into each tlb slot
    logic [18:0]   e_vpn2 [TLB_ENTRIES];
    logic [7:0]    e_asid [TLB_ENTRIES];
    logic [31:0]   e_lo0 [TLB_ENTRIES];
    logic [31:0]   e_lo1 [TLB_ENTRIES];

    cp0_tlb_top #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) u_cp0_tlb_top (
        .clk             (clk),
        .rst             (rst),
        .wr_i            (wr),
        .rd_addr_i       (rd_addr),
        .rd_data_o       (rd_data),
        .exc_i           (exc),
        .clear_exl_i     (clear_exl),
        .hw_int_i        (hw_int),
        .tlb_op_i        (tlb_op),
        .daddr_i         (daddr),
        .epc_o           (epc),
        .exl_o           (exl),
        .allow_int_o     (allow_int),
        .interrupt_flag_o(interrupt_flag),
        .dtrans_o        (dtrans)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // xorshift32
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // hit result from entrylo layout: pfn 25:6, c 5:3, d 2, v 1
    function automatic tlb_result_t expect_hit(input logic [31:0] lo, input int slot,
                                               input logic [31:0] va);
        tlb_result_t r;
        r = '0;
        r.hit    = 1'b1;
        r.index  = 5'(slot);
        r.pa     = {lo[25:6], va[11:0]};
        r.valid  = lo[1];
        r.dirty  = lo[2];
        r.cached = (lo[5:3] == 3'd3);
        return r;
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
        checks++;
        assert (act == exp) else begin
            $display("Fail %s: expected 0x%0h, actual 0x%0h", name, exp, act);
            errors++;
        end
    endtask

    // one mtc0, visible from the next edge on
    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        wr.we   = 1'b1;
        wr.addr = addr;
        wr.data = data;
        @(posedge clk);
        #2;
        wr.we = 1'b0;
    endtask

    // mfc0 is combinational
    task automatic read_reg(input logic [4:0] addr, output logic [31:0] data);
        rd_addr = addr;
        #1;
        data = rd_data;
    endtask

    task automatic check_reg(input string name, input logic [4:0] addr,
                             input logic [31:0] exp);
        logic [31:0] val;
        read_reg(addr, val);
        check_val(name, 64'(exp), 64'(val));
    endtask

    // single-cycle tlbwi/tlbr/tlbp strobe
    task automatic tlb_strobe(input tlb_op_t op);
        @(posedge clk);
        #2;
        tlb_op = op;
        @(posedge clk);
        #2;
        tlb_op = '0;
    endtask

    task automatic pulse_clear_exl();
        @(posedge clk);
        #2;
        clear_exl = 1'b1;
        @(posedge clk);
        #2;
        clear_exl = 1'b0;
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %0d checks, %0d failures", num, name,
                 checks - checks_at, errors - errors_at);
        checks_at = checks;
        errors_at = errors;
    endtask

    initial begin
        logic [31:0] d;
        logic [31:0] v;
        logic [31:0] c;
        logic [31:0] exp;
        logic [31:0] va;
        logic [31:0] lo;
        logic [31:0] eh_set;
        logic [31:0] exc_cause;
        logic [4:0]  reg_list [11];
        logic [7:0]  im;
        logic [1:0]  sw;
        logic [2:0]  k;
        logic        g;
        logic        fired;
        exc_req_t    req;

        rng_state = 32'h3172;
        checks    = 0;
        errors    = 0;
        checks_at = 0;
        errors_at = 0;
        rst       = 1'b1;
        wr        = '0;
        rd_addr   = '0;
        exc       = '0;
        clear_exl = 1'b0;
        hw_int    = '0;
        tlb_op    = '0;
        daddr     = '0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        // 1: reset values
        check_reg("status", CP0_STATUS, BEV_BIT);
        check_reg("epc", CP0_EPC, 32'h0);
        check_reg("cause", CP0_CAUSE, 32'h0);
        check_val("exl_o", 64'h0, 64'(exl));
        check_val("allow_int_o", 64'h0, 64'(allow_int));
        check_val("interrupt_flag_o", 64'h0, 64'(interrupt_flag));
        end_test(1, "reset state");

        // 2: compare is written before cause so ti is clear there
        reg_list = '{CP0_INDEX, CP0_ENTRYLO0, CP0_ENTRYLO1, CP0_BADVADDR, CP0_COUNT,
                     CP0_ENTRYHI, CP0_COMPARE, CP0_STATUS, CP0_CAUSE, CP0_EPC, CP0_NONE};
        foreach (reg_list[j]) begin
            d = next_rand();
            write_reg(reg_list[j], d);
            case (reg_list[j])
                CP0_INDEX:    exp = d & M_INDEX;
                CP0_ENTRYLO0: exp = d & M_ENTRYLO;
                CP0_ENTRYLO1: exp = d & M_ENTRYLO;
                CP0_ENTRYHI:  exp = d & M_ENTRYHI;
                CP0_STATUS:   exp = (d & M_STATUS) | BEV_BIT;
                CP0_CAUSE:    exp = d & M_CAUSE_SW;
                // read only, or not implemented
                CP0_BADVADDR: exp = 32'h0;
                CP0_NONE:     exp = 32'h0;
                default:      exp = d;
            endcase
            check_reg($sformatf("rd_data_o[reg %0d]", reg_list[j]), reg_list[j], exp);
        end
        end_test(2, "mtc0/mfc0 masks");

        // 3: park the timer far away first
        write_reg(CP0_STATUS, 32'h0);
        write_reg(CP0_CAUSE, 32'h0);
        write_reg(CP0_COUNT, 32'h0);
        write_reg(CP0_COMPARE, 32'hffff_ffff);
        eh_set = next_rand() & M_ENTRYHI;
        write_reg(CP0_ENTRYHI, eh_set);
        d = next_rand();
        req             = '0;
        req.valid       = 1'b1;
        req.bd          = 1'b1;
        req.code        = d[4:0];
        req.epc         = next_rand();
        req.badvaddr    = next_rand();
        req.badvaddr_we = 1'b1;
        exc_cause = 32'h8000_0000 | (32'(req.code) << 2);
        @(posedge clk);
        #2;
        exc = req;
        @(posedge clk);
        #2;
        exc = '0;
        check_val("exl_o", 64'h1, 64'(exl));
        check_val("epc_o", 64'(req.epc), 64'(epc));
        check_reg("cause", CP0_CAUSE, exc_cause);
        check_reg("badvaddr", CP0_BADVADDR, req.badvaddr);
        // vpn2 from the bad address, asid kept
        check_reg("entryhi", CP0_ENTRYHI, (req.badvaddr & 32'hffff_e000) | (eh_set & 32'hff));
        // ie on, exl still held
        write_reg(CP0_STATUS, 32'h3);
        check_val("allow_int_o", 64'h0, 64'(allow_int));
        pulse_clear_exl();
        check_val("exl_o", 64'h0, 64'(exl));
        check_val("allow_int_o", 64'h1, 64'(allow_int));
        check_reg("status", CP0_STATUS, BEV_BIT | 32'h1);
        // request itself masks interrupts in its own cycle
        req.badvaddr_we = 1'b0;
        @(posedge clk);
        #2;
        exc = req;
        #1;
        check_val("allow_int_o", 64'h0, 64'(allow_int));
        @(posedge clk);
        #2;
        exc = '0;
        check_val("exl_o", 64'h1, 64'(exl));
        pulse_clear_exl();
        check_val("exl_o", 64'h0, 64'(exl));
        end_test(3, "exception entry and clear");

        // 4: only ip7 unmasked
        write_reg(CP0_STATUS, 32'h0000_8000);
        read_reg(CP0_COUNT, c);
        write_reg(CP0_COMPARE, c + 32'd10);
        fired = 1'b0;
        for (int n = 0; n < 60 && !fired; n++) begin
            @(posedge clk);
            #2;
            read_reg(CP0_CAUSE, v);
            fired = v[30];
        end
        checks++;
        assert (fired) else begin
            $display("timeout: the timer interrupt did not reach Cause.TI within 60 cycles");
            errors++;
        end
        check_val("interrupt_flag_o", 64'h80, 64'(interrupt_flag));
        check_reg("cause", CP0_CAUSE, exc_cause | 32'h4000_0000);
        write_reg(CP0_COMPARE, c + 32'd100000);
        check_reg("cause", CP0_CAUSE, exc_cause);
        check_val("interrupt_flag_o", 64'h0, 64'(interrupt_flag));
        // ip = hw lines on 7:2, software bits on 1:0
        d  = next_rand();
        im = d[15:8];
        sw = d[1:0];
        write_reg(CP0_STATUS, 32'(im) << 8);
        write_reg(CP0_CAUSE, 32'(sw) << 8);
        repeat (4) begin
            d = next_rand();
            @(posedge clk);
            #2;
            hw_int = d[5:0];
            #1;
            check_val("interrupt_flag_o", 64'(im & {d[5:0], sw}), 64'(interrupt_flag));
            check_reg("cause", CP0_CAUSE,
                      exc_cause | (32'(d[5:0]) << 10) | (32'(sw) << 8));
        end
        hw_int = '0;
        end_test(4, "timer interrupt");

        // 5: vpn2 bit 3 clear in every slot, low bits give the slot
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            d = next_rand();
            e_vpn2[i] = {d[31:17], 1'b0, 3'(i)};
            e_asid[i] = d[7:0];
            e_lo0[i]  = next_rand() & M_ENTRYLO;
            e_lo1[i]  = next_rand() & M_ENTRYLO;
            // slot 0 global, slot 1 global in one half only
            if (i < 2) begin
                e_lo0[i][0] = 1'b1;
                e_lo1[i][0] = (i == 0);
            end
            write_reg(CP0_ENTRYHI, {e_vpn2[i], 5'b0, e_asid[i]});
            write_reg(CP0_ENTRYLO0, e_lo0[i]);
            write_reg(CP0_ENTRYLO1, e_lo1[i]);
            write_reg(CP0_INDEX, 32'(i));
            // tlbwi
            tlb_strobe(3'b100);
        end
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            write_reg(CP0_ENTRYHI, {e_vpn2[i], 5'b0, e_asid[i]});
            for (int p = 0; p < 2; p++) begin
                d  = next_rand();
                va = {e_vpn2[i], 1'(p), d[11:0]};
                lo = (p == 1) ? e_lo1[i] : e_lo0[i];
                @(posedge clk);
                #2;
                daddr = va;
                #1;
                check_val($sformatf("dtrans_o[slot %0d page %0d]", i, p),
                          64'(expect_hit(lo, i, va)), 64'(dtrans));
            end
            // own asid still current, so only the vpn2 can miss
            @(posedge clk);
            #2;
            daddr = {e_vpn2[i] | 19'h8, d[12:0]};
            #1;
            check_val($sformatf("dtrans_o[slot %0d unused vpn2]", i), 64'h0, 64'(dtrans));
            // other asid, only a global entry still hits
            write_reg(CP0_ENTRYHI, {e_vpn2[i], 5'b0, e_asid[i] ^ 8'h5a});
            daddr = va;
            #1;
            g = e_lo0[i][0] & e_lo1[i][0];
            check_val($sformatf("dtrans_o[slot %0d asid]", i),
                      g ? 64'(expect_hit(lo, i, va)) : 64'h0, 64'(dtrans));
        end
        end_test(5, "tlbwi and translation");

        // 6: probe hit, probe miss, then read back over clobbered registers
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            k = 3'(i);
            write_reg(CP0_ENTRYHI, {e_vpn2[k], 5'b0, e_asid[k]});
            tlb_strobe(3'b001);
            check_reg("index", CP0_INDEX, 32'(k));
            write_reg(CP0_ENTRYHI, {e_vpn2[k] | 19'h8, 5'b0, e_asid[k]});
            tlb_strobe(3'b001);
            read_reg(CP0_INDEX, v);
            check_val("index.p", 64'h1, 64'(v[31]));
            write_reg(CP0_INDEX, 32'(k));
            write_reg(CP0_ENTRYHI, next_rand());
            write_reg(CP0_ENTRYLO0, next_rand());
            write_reg(CP0_ENTRYLO1, next_rand());
            tlb_strobe(3'b010);
            g = e_lo0[k][0] & e_lo1[k][0];
            check_reg("entryhi", CP0_ENTRYHI, {e_vpn2[k], 5'b0, e_asid[k]});
            check_reg("entrylo0", CP0_ENTRYLO0, {e_lo0[k][31:1], g});
            check_reg("entrylo1", CP0_ENTRYLO1, {e_lo1[k][31:1], g});
        end
        end_test(6, "tlbp and tlbr");

        $display("%0d checks, %0d failures", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
design/cp0_pkg.sv
design/tlb_pkg.sv
design/tlb_lookup.sv
design/tlb_array.sv
design/cp0_regs.sv
design/cp0_tlb_top.sv
dv/cp0_tlb_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -f vlog.f --top-module cp0_tlb_tb &&
    ./obj_dir/Vcp0_tlb_tb | tee /dev/stderr | grep -qF "Simulation finished: PASS" &&
    echo "run.sh: simulation passed" ||
    { echo "run.sh: build or simulation failed" >&2; exit 1; }
